//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_adc_write
FILELIST  := build.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

# build, run, then pass only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/adc_write_assert.sv
`timescale 1ns/1ps

module adc_write_assert (
	input logic                                  clk,
	input logic                                  reset,
	input logic                                  live_rising,
	input logic                                  get_package,
	input logic [ram_bank_pkg::data_w-1:0]        input_data,
	input logic [adc_package_pkg::half_len_w-1:0] half_package_length,
	input logic [ram_bank_pkg::addr_w-1:0]        memory_depth,
	input logic [1:0]                            sel,
	input logic [ram_bank_pkg::data_w-1:0]        even_data,
	input logic [ram_bank_pkg::addr_w-1:0]        even_addr,
	input logic                                  even_wren,
	input logic [ram_bank_pkg::data_w-1:0]        odd_data,
	input logic [ram_bank_pkg::addr_w-1:0]        odd_addr,
	input logic                                  odd_wren,
	input logic                                  complete
);
	import adc_package_pkg::*;
	import ram_bank_pkg::*;

	// read by the testbench at the end of the run
	int fail_count = 0;

	logic               shadow_busy;
	logic [count_w-1:0] shadow_k;
	logic [addr_w-1:0]  shadow_base;
	logic [count_w-1:0] pkg_len;
	energy_idx_u        e_idx;
	logic               exp_energy;
	logic               exp_odd;
	logic               exp_last;
	logic [addr_w-1:0]  exp_addr;
	logic [data_w-1:0]  exp_data;
	// two stages, router then bank port
	logic               valid_q1;
	logic               valid_q2;
	logic               last_q1;
	logic               last_q2;
	logic               odd_q1;
	logic               odd_q2;
	logic [addr_w-1:0]  addr_q1;
	logic [addr_w-1:0]  addr_q2;
	logic [data_w-1:0]  data_q1;
	logic [data_w-1:0]  data_q2;

	////////////////////////////////////////////////////////////
	// shadow counter and base, from top level inputs only
	////////////////////////////////////////////////////////////

	assign pkg_len = count_w'(half_package_length) * 2;

	always_ff @(posedge clk) begin
		if (reset || live_rising) begin
			shadow_busy <= 1'b0;
			shadow_k    <= '0;
			shadow_base <= memory_depth - addr_w'(half_package_length);
		end else if (get_package) begin
			shadow_busy <= 1'b1;
			shadow_k    <= '0;
			// wrap when the next half package would reach the depth
			if (int'(shadow_base) + int'(half_package_length) >= int'(memory_depth)) begin
				shadow_base <= '0;
			end else begin
				shadow_base <= shadow_base + addr_w'(half_package_length);
			end
		end else if (shadow_busy) begin
			if (shadow_k == pkg_len - 12'd1) begin
				shadow_busy <= 1'b0;
			end
			shadow_k <= shadow_k + 12'd1;
		end
	end

	////////////////////////////////////////////////////////////
	// expected write for the word on input_data now
	////////////////////////////////////////////////////////////

	assign exp_energy = (int'(shadow_k) >= header_words)
		&& (int'(shadow_k) < header_words + energy_words);
	assign e_idx.raw  = 10'(int'(shadow_k) - header_words);
	assign exp_odd    = exp_energy ? e_idx.fields.sample_id[0] : shadow_k[0];
	assign exp_last   = shadow_busy && (shadow_k == pkg_len - 12'd1);

	always_comb begin
		if (exp_energy) begin
			// transpose, sample pairs along the row, channel picks the row
			exp_addr = addr_w'(int'(shadow_base) + header_bank_offset
				+ int'(e_idx.fields.sample_id) / 2
				+ int'(e_idx.fields.channel_id) * channel_stride);
			case (sel)
				mode_constant:  exp_data = constant_word;
				mode_delta: begin
					if (int'(e_idx.raw) >= delta_peak_first
						&& int'(e_idx.raw) < delta_peak_first + channels) begin
						exp_data = delta_peak_word;
					end else begin
						exp_data = delta_base_word;
					end
				end
				mode_alternate: exp_data = exp_odd ? alternate_odd_word : alternate_even_word;
				default:        exp_data = input_data;
			endcase
		end else begin
			// header and footer, two words per bank address
			exp_addr = addr_w'(int'(shadow_base) + int'(shadow_k) / 2);
			exp_data = input_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q1 <= 1'b0;
			valid_q2 <= 1'b0;
			last_q1  <= 1'b0;
			last_q2  <= 1'b0;
		end else begin
			valid_q1 <= shadow_busy;
			valid_q2 <= valid_q1;
			last_q1  <= exp_last;
			last_q2  <= last_q1;
		end
	end

	always_ff @(posedge clk) begin
		odd_q1  <= exp_odd;
		odd_q2  <= odd_q1;
		addr_q1 <= exp_addr;
		addr_q2 <= addr_q1;
		data_q1 <= exp_data;
		data_q2 <= data_q1;
	end

	////////////////////////////////////////////////////////////
	// checks on the bank ports
	////////////////////////////////////////////////////////////

	even_write_check: assert property (@(posedge clk) disable iff (reset)
		(valid_q2 && !odd_q2) |-> (even_wren && !odd_wren
			&& even_addr == addr_q2 && even_data == data_q2))
		else begin
			fail_count++;
			$error("Mismatch at %0t: even write, expected addr %h data %h", $time,
				addr_q2, data_q2);
		end

	odd_write_check: assert property (@(posedge clk) disable iff (reset)
		(valid_q2 && odd_q2) |-> (odd_wren && !even_wren
			&& odd_addr == addr_q2 && odd_data == data_q2))
		else begin
			fail_count++;
			$error("Mismatch at %0t: odd write, expected addr %h data %h", $time,
				addr_q2, data_q2);
		end

	// no strobe outside a package, after reset or after live_rising
	idle_check: assert property (@(posedge clk) disable iff (reset)
		!valid_q2 |-> (!even_wren && !odd_wren))
		else begin
			fail_count++;
			$error("Mismatch at %0t: write strobe high with no word in flight", $time);
		end

	complete_check: assert property (@(posedge clk) disable iff (reset)
		complete == last_q2)
		else begin
			fail_count++;
			$error("Mismatch at %0t: complete is %b, expected %b", $time, complete, last_q2);
		end

	// a bank left alone keeps its address
	hold_check: assert property (@(posedge clk) disable iff (reset)
		(even_wren || $stable(even_addr)) && (odd_wren || $stable(odd_addr)))
		else begin
			fail_count++;
			$error("Mismatch at %0t: idle bank address moved", $time);
		end

endmodule

bind adc_write_top adc_write_assert adc_write_assert_inst (.*);

//--- bench/tb_adc_write.sv
`timescale 1ns/1ps

module tb_adc_write;
	import adc_package_pkg::*;
	import ram_bank_pkg::*;

	// eleven packages of 1036 words, each with a gap of at most 20
	// plus reset and live_rising, about 11700 cycles
	localparam int timeout_cycles = 12000;
	localparam int reset_cycles   = 8;
	localparam int half_len       = 518;

	logic                  clk;
	logic                  reset;
	logic                  live_rising;
	logic                  get_package;
	logic [data_w-1:0]     input_data;
	logic [half_len_w-1:0] half_package_length;
	logic [addr_w-1:0]     memory_depth;
	logic [1:0]            sel;
	logic [data_w-1:0]     even_data;
	logic [addr_w-1:0]     even_addr;
	logic                  even_wren;
	logic [data_w-1:0]     odd_data;
	logic [addr_w-1:0]     odd_addr;
	logic                  odd_wren;
	logic                  complete;

	int cycle_count    = 0;
	int packages_sent  = 0;
	int completes_seen = 0;
	int other_errors   = 0;
	int assert_errors;

	adc_write_top adc_write_top_inst (
		.clk                 (clk),
		.reset               (reset),
		.live_rising         (live_rising),
		.get_package         (get_package),
		.input_data          (input_data),
		.half_package_length (half_package_length),
		.memory_depth        (memory_depth),
		.sel                 (sel),
		.even_data           (even_data),
		.even_addr           (even_addr),
		.even_wren           (even_wren),
		.odd_data            (odd_data),
		.odd_addr            (odd_addr),
		.odd_wren            (odd_wren),
		.complete            (complete)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// run limit and complete counter
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: run still busy after %0d cycles", cycle_count);
			$display("Finished with errors");
			$finish;
		end
	end

	always @(posedge clk) begin
		if (!reset && complete) begin
			completes_seen = completes_seen + 1;
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus tasks
	////////////////////////////////////////////////////////////

	// 2 to 20 idle cycles between packages
	task automatic idle_gap();
		repeat (2 + ($urandom() % 19)) @(posedge clk);
	endtask

	// strobe, then one random word per cycle with no gaps
	task automatic run_package(input logic [1:0] mode);
		idle_gap();
		@(posedge clk);
		sel         <= mode;
		get_package <= 1'b1;
		for (int k = 0; k < 2 * half_len; k++) begin
			@(posedge clk);
			get_package <= 1'b0;
			input_data  <= data_w'($urandom());
		end
		packages_sent = packages_sent + 1;
	endtask

	task automatic change_depth(input int depth);
		@(posedge clk);
		memory_depth <= addr_w'(depth);
	endtask

	task automatic pulse_live_rising();
		idle_gap();
		@(posedge clk);
		live_rising <= 1'b1;
		@(posedge clk);
		live_rising <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'hcef6_330a));
		reset               = 1'b1;
		live_rising         = 1'b0;
		get_package         = 1'b0;
		input_data          = '0;
		half_package_length = half_len_w'(half_len);
		memory_depth        = addr_w'(2048);
		sel                 = mode_standard;
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;

		// base 0 then 518
		run_package(mode_standard);
		run_package(mode_standard);
		// shorter memory, base goes 1036 and then wraps to 0
		change_depth(1200);
		run_package(mode_standard);
		run_package(mode_standard);
		change_depth(2048);
		run_package(mode_standard);
		// next package lands at 0 again
		pulse_live_rising();
		run_package(mode_constant);
		run_package(mode_constant);
		run_package(mode_delta);
		run_package(mode_delta);
		run_package(mode_alternate);
		run_package(mode_alternate);

		// wait for the last write to drain
		while (completes_seen < packages_sent) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);

		if (completes_seen != packages_sent) begin
			$display("complete pulsed %0d times for %0d packages", completes_seen,
				packages_sent);
			other_errors = other_errors + 1;
		end
		assert_errors = adc_write_top_inst.adc_write_assert_inst.fail_count;
		$display("packages %0d, completes %0d, assertion errors %0d, other errors %0d",
			packages_sent, completes_seen, assert_errors, other_errors);
		if (assert_errors == 0 && other_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- build.f
hw/adc_package_pkg.sv
hw/ram_bank_pkg.sv
hw/fake_pattern_gen.sv
hw/bank_write_port.sv
hw/package_sequencer.sv
hw/word_router.sv
hw/adc_write_top.sv
bench/adc_write_assert.sv
bench/tb_adc_write.sv

//--- hw/adc_package_pkg.sv
package adc_package_pkg;

	////////////////////////////////////////////////////////////
	// package layout as seen on the ADC word stream
	////////////////////////////////////////////////////////////

	// header words that lead every package
	localparam int header_words = 6;

	// energy region, 16 channels by 64 samples
	localparam int energy_words = 1024;

	// channels interleaved inside one sample
	localparam int channels = 16;

	// address step per channel inside one bank
	// 64 samples per channel split over two banks
	localparam int channel_stride = 32;

	// each bank holds half the header ahead of the energy words
	localparam int header_bank_offset = 3;

	// word counter, wide enough for twice the half length plus idle
	localparam int count_w = 12;

	// width of the half package length input
	localparam int half_len_w = 10;

	////////////////////////////////////////////////////////////
	// energy index views
	////////////////////////////////////////////////////////////

	// word number minus header_words, split into its two fields
	// channel runs fastest on the stream
	typedef struct packed {
		logic [5:0] sample_id;
		logic [3:0] channel_id;
	} energy_fields_t;

	// raw for range checks, fields for the transpose
	// sample_id[0] is the bank parity
	typedef union packed {
		logic [9:0]     raw;
		energy_fields_t fields;
	} energy_idx_u;

endpackage

//--- hw/adc_write_top.sv
`timescale 1ns/1ps

module adc_write_top (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  live_rising,
	input  logic                                  get_package,
	input  logic [ram_bank_pkg::data_w-1:0]        input_data,
	input  logic [adc_package_pkg::half_len_w-1:0] half_package_length,
	input  logic [ram_bank_pkg::addr_w-1:0]        memory_depth,
	input  logic [1:0]                            sel,
	output logic [ram_bank_pkg::data_w-1:0]        even_data,
	output logic [ram_bank_pkg::addr_w-1:0]        even_addr,
	output logic                                  even_wren,
	output logic [ram_bank_pkg::data_w-1:0]        odd_data,
	output logic [ram_bank_pkg::addr_w-1:0]        odd_addr,
	output logic                                  odd_wren,
	output logic                                  complete
);
	import adc_package_pkg::*;
	import ram_bank_pkg::*;

	// sequencer to router
	logic [count_w-1:0] word_index;
	logic               word_valid;
	logic [addr_w-1:0]  base_addr;

	// router to bank ports
	logic               even_write;
	logic [addr_w-1:0]  even_addr_next;
	logic [data_w-1:0]  even_data_next;
	logic               odd_write;
	logic [addr_w-1:0]  odd_addr_next;
	logic [data_w-1:0]  odd_data_next;

	package_sequencer package_sequencer_inst (
		.clk                 (clk),
		.reset               (reset),
		.live_rising         (live_rising),
		.get_package         (get_package),
		.half_package_length (half_package_length),
		.memory_depth        (memory_depth),
		.word_index          (word_index),
		.word_valid          (word_valid),
		.base_addr           (base_addr),
		.complete            (complete)
	);

	word_router word_router_inst (
		.clk            (clk),
		.reset          (reset),
		.word_index     (word_index),
		.word_valid     (word_valid),
		.base_addr      (base_addr),
		.input_data     (input_data),
		.sel            (sel),
		.even_write     (even_write),
		.even_addr_next (even_addr_next),
		.even_data_next (even_data_next),
		.odd_write      (odd_write),
		.odd_addr_next  (odd_addr_next),
		.odd_data_next  (odd_data_next)
	);

	// even bank, h0 h2 h4 and even samples
	bank_write_port even_port_inst (
		.clk       (clk),
		.reset     (reset),
		.write     (even_write),
		.addr_next (even_addr_next),
		.data_next (even_data_next),
		.wren      (even_wren),
		.addr      (even_addr),
		.data      (even_data)
	);

	// odd bank, h1 h3 h5 and odd samples
	bank_write_port odd_port_inst (
		.clk       (clk),
		.reset     (reset),
		.write     (odd_write),
		.addr_next (odd_addr_next),
		.data_next (odd_data_next),
		.wren      (odd_wren),
		.addr      (odd_addr),
		.data      (odd_data)
	);

endmodule

//--- hw/bank_write_port.sv
`timescale 1ns/1ps

module bank_write_port (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           write,
	input  logic [ram_bank_pkg::addr_w-1:0] addr_next,
	input  logic [ram_bank_pkg::data_w-1:0] data_next,
	output logic                           wren,
	output logic [ram_bank_pkg::addr_w-1:0] addr,
	output logic [ram_bank_pkg::data_w-1:0] data
);

	////////////////////////////////////////////////////////////
	// output stage of one RAM bank
	////////////////////////////////////////////////////////////

	// strobe and address, parked at the top address after reset
	always_ff @(posedge clk) begin
		if (reset) begin
			wren <= 1'b0;
			addr <= '1;
		end else begin
			wren <= write;
			// hold the last address while the other bank is busy
			if (write) begin
				addr <= addr_next;
			end
		end
	end

	// data follows the same hold rule
	always_ff @(posedge clk) begin
		if (write) begin
			data <= data_next;
		end
	end

endmodule

//--- hw/fake_pattern_gen.sv
`timescale 1ns/1ps

module fake_pattern_gen (
	input  adc_package_pkg::energy_idx_u     energy_index,
	input  logic [1:0]                      mode,
	input  logic [ram_bank_pkg::data_w-1:0] input_data,
	output logic [ram_bank_pkg::data_w-1:0] energy_data
);
	import adc_package_pkg::*;
	import ram_bank_pkg::*;

	logic in_peak;

	// peak covers one full sample, all 16 channels
	assign in_peak = (int'(energy_index.raw) >= delta_peak_first)
		&& (int'(energy_index.raw) < delta_peak_first + channels);

	always_comb begin
		case (mode)
			mode_constant: begin
				energy_data = constant_word;
			end
			mode_delta: begin
				energy_data = in_peak ? delta_peak_word : delta_base_word;
			end
			mode_alternate: begin
				// sample parity is also the bank choice
				if (energy_index.fields.sample_id[0]) begin
					energy_data = alternate_odd_word;
				end else begin
					energy_data = alternate_even_word;
				end
			end
			default: begin
				// standard mode, live ADC data
				energy_data = input_data;
			end
		endcase
	end

endmodule

//--- hw/package_sequencer.sv
`timescale 1ns/1ps

module package_sequencer (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  live_rising,
	input  logic                                  get_package,
	input  logic [adc_package_pkg::half_len_w-1:0] half_package_length,
	input  logic [ram_bank_pkg::addr_w-1:0]        memory_depth,
	output logic [adc_package_pkg::count_w-1:0]    word_index,
	output logic                                  word_valid,
	output logic [ram_bank_pkg::addr_w-1:0]        base_addr,
	output logic                                  complete
);
	import adc_package_pkg::*;
	import ram_bank_pkg::*;

	logic [count_w-1:0] package_length;
	// one extra bit so the wrap compare never overflows
	logic [addr_w:0]    base_sum;
	logic               last_word;
	logic               last_word_d;

	// package length is always even
	assign package_length = count_w'({half_package_length, 1'b0});

	// counter sits at or above the length when idle
	assign word_valid = word_index < package_length;
	assign last_word  = word_valid && (word_index == package_length - 1'b1);

	// next base if the package still fits below memory_depth
	assign base_sum = {1'b0, base_addr} + (addr_w + 1)'(half_package_length);

	////////////////////////////////////////////////////////////
	// word counter and base address
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset || live_rising) begin
			// all ones is past any legal length, so idle
			word_index <= '1;
			// first get_package after this lands the base at 0
			base_addr <= memory_depth - addr_w'(half_package_length);
		end else if (get_package) begin
			// word 0 is on input_data next cycle
			word_index <= '0;
			if (base_sum >= {1'b0, memory_depth}) begin
				base_addr <= '0;
			end else begin
				base_addr <= base_sum[addr_w-1:0];
			end
		end else if (word_valid) begin
			// saturates at package_length
			word_index <= word_index + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// complete, lined up with the last bank write
	////////////////////////////////////////////////////////////

	// two stages match router register plus bank port register
	always_ff @(posedge clk) begin
		if (reset || live_rising) begin
			last_word_d <= 1'b0;
			complete    <= 1'b0;
		end else begin
			last_word_d <= last_word;
			complete    <= last_word_d;
		end
	end

endmodule

//--- hw/ram_bank_pkg.sv
package ram_bank_pkg;

	////////////////////////////////////////////////////////////
	// bank geometry
	////////////////////////////////////////////////////////////

	localparam int addr_w = 14;
	localparam int data_w = 16;

	// data mode select, sel input of the top
	localparam logic [1:0] mode_standard  = 2'd0;
	localparam logic [1:0] mode_constant  = 2'd1;
	localparam logic [1:0] mode_delta     = 2'd2;
	localparam logic [1:0] mode_alternate = 2'd3;

	////////////////////////////////////////////////////////////
	// fake energy words
	////////////////////////////////////////////////////////////

	// flat level in every energy slot
	localparam logic [15:0] constant_word = 16'h8e14;

	// delta mode, baseline and the single peak sample
	localparam logic [15:0] delta_base_word = 16'h8001;
	localparam logic [15:0] delta_peak_word = 16'hb000;

	// first energy index of the peak, one sample of 16 channels
	localparam int delta_peak_first = 480;

	// alternate mode, word depends on the bank written
	localparam logic [15:0] alternate_even_word = 16'h8001;
	localparam logic [15:0] alternate_odd_word  = 16'hb000;

endpackage

//--- hw/word_router.sv
`timescale 1ns/1ps

module word_router (
	input  logic                               clk,
	input  logic                               reset,
	input  logic [adc_package_pkg::count_w-1:0] word_index,
	input  logic                               word_valid,
	input  logic [ram_bank_pkg::addr_w-1:0]     base_addr,
	input  logic [ram_bank_pkg::data_w-1:0]     input_data,
	input  logic [1:0]                         sel,
	output logic                               even_write,
	output logic [ram_bank_pkg::addr_w-1:0]     even_addr_next,
	output logic [ram_bank_pkg::data_w-1:0]     even_data_next,
	output logic                               odd_write,
	output logic [ram_bank_pkg::addr_w-1:0]     odd_addr_next,
	output logic [ram_bank_pkg::data_w-1:0]     odd_data_next
);
	import adc_package_pkg::*;
	import ram_bank_pkg::*;

	logic [count_w-1:0] energy_offset;
	logic               is_energy;
	energy_idx_u        energy_idx;
	logic [data_w-1:0]  energy_data;
	logic               odd_bank;
	logic [addr_w-1:0]  header_addr;
	logic [addr_w-1:0]  energy_addr;
	logic [addr_w-1:0]  word_addr;
	logic [data_w-1:0]  word_data;
	// first pipeline stage, shared by both banks
	logic [addr_w-1:0]  addr_q;
	logic [data_w-1:0]  data_q;

	////////////////////////////////////////////////////////////
	// decode and transpose
	////////////////////////////////////////////////////////////

	assign energy_offset = word_index - count_w'(header_words);
	assign is_energy = (word_index >= count_w'(header_words))
		&& (word_index < count_w'(header_words + energy_words));

	// only the low bits matter inside the energy region
	assign energy_idx.raw = energy_offset[$bits(energy_idx_u)-1:0];

	// headers and footer alternate by word parity
	// energy words go by sample parity
	assign odd_bank = is_energy ? energy_idx.fields.sample_id[0] : word_index[0];

	// two words per address across the bank pair
	assign header_addr = base_addr + addr_w'(word_index[count_w-1:1]);

	// sample pairs run along the channel row, channels stride by 32
	// wraps modulo the bank size
	assign energy_addr = base_addr + addr_w'(header_bank_offset)
		+ addr_w'(energy_idx.fields.sample_id >> 1)
		+ addr_w'(energy_idx.fields.channel_id) * addr_w'(channel_stride);

	fake_pattern_gen fake_pattern_gen_inst (
		.energy_index (energy_idx),
		.mode         (sel),
		.input_data   (input_data),
		.energy_data  (energy_data)
	);

	// mode only touches energy words, header and footer pass as is
	assign word_addr = is_energy ? energy_addr : header_addr;
	assign word_data = is_energy ? energy_data : input_data;

	////////////////////////////////////////////////////////////
	// register stage
	////////////////////////////////////////////////////////////

	// one strobe at most, picked by the bank choice
	always_ff @(posedge clk) begin
		if (reset) begin
			even_write <= 1'b0;
			odd_write  <= 1'b0;
		end else begin
			even_write <= word_valid && !odd_bank;
			odd_write  <= word_valid && odd_bank;
		end
	end

	// payload, qualified later by the strobes
	always_ff @(posedge clk) begin
		addr_q <= word_addr;
		data_q <= word_data;
	end

	assign even_addr_next = addr_q;
	assign even_data_next = data_q;
	assign odd_addr_next  = addr_q;
	assign odd_data_next  = data_q;

endmodule
